// ==== logic/reservation_station.sv ====
module reservation_station (
    input  logic clock,
    input  logic reset,
    input  logic allocate,
    input  rs_pkg::rs_packet_t alloc_packet,
    input  logic update,
    input  rs_pkg::tag_t ready_tag,
    input  logic issue_enable,
    input  rs_pkg::slot_mask_t free [rs_pkg::num_fu_types],
    output logic done,
    output rs_pkg::issue_packet_t issued,
    output rs_pkg::bank_mask_t bank_full
);

    import rs_pkg::*;

    bank_mask_t bank_write;
    bank_mask_t issue_ready;
    bank_mask_t issue_grant;
    rs_packet_t bank_packet [num_fu_types];
    slot_t bank_slot [num_fu_types];

    // allocation into the bank of the packet's function type
    rs_alloc_router u_router (
        .clock        (clock),
        .reset        (reset),
        .allocate     (allocate),
        .alloc_packet (alloc_packet),
        .bank_full    (bank_full),
        .bank_write   (bank_write),
        .done         (done)
    );

    // one bank per function type, index matches fu_type_e
    for (genvar b = 0; b < num_fu_types; b++) begin : g_bank
        rs_bank u_bank (
            .clock        (clock),
            .reset        (reset),
            .write        (bank_write[b]),
            .write_packet (alloc_packet),
            .update       (update),
            .ready_tag    (ready_tag),
            .issue_grant  (issue_grant[b]),
            .free         (free[b]),
            .full         (bank_full[b]),
            .issue_ready  (issue_ready[b]),
            .issue_packet (bank_packet[b]),
            .issue_slot   (bank_slot[b])
        );
    end

    rs_issue_select u_select (
        .clock        (clock),
        .reset        (reset),
        .issue_enable (issue_enable),
        .issue_ready  (issue_ready),
        .bank_packet  (bank_packet),
        .bank_slot    (bank_slot),
        .issue_grant  (issue_grant),
        .issued       (issued)
    );

endmodule

// ==== logic/rs_alloc_router.sv ====
module rs_alloc_router (
    input  logic clock,
    input  logic reset,
    input  logic allocate,
    input  rs_pkg::rs_packet_t alloc_packet,
    input  rs_pkg::bank_mask_t bank_full,
    output rs_pkg::bank_mask_t bank_write,
    output logic done
);

    import rs_pkg::*;

    logic type_known;

    // only the five defined function types map to a bank
    always_comb begin
        case (alloc_packet.fu_type)
            fu_alu,
            fu_mult,
            fu_load,
            fu_store,
            fu_branch: type_known = 1'b1;
            default: type_known = 1'b0;
        endcase
    end

    // one-hot write strobe into the target bank
    always_comb begin
        bank_write = '0;
        if (allocate && type_known) begin
            // a full bank refuses, the caller has to retry
            if (!bank_full[alloc_packet.fu_type]) begin
                bank_write[alloc_packet.fu_type] = 1'b1;
            end
        end
    end

    // done follows the accepted write by one cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= |bank_write;
        end
    end

endmodule

// ==== logic/rs_bank.sv ====
module rs_bank (
    input  logic clock,
    input  logic reset,
    input  logic write,
    input  rs_pkg::rs_packet_t write_packet,
    input  logic update,
    input  rs_pkg::tag_t ready_tag,
    input  logic issue_grant,
    input  rs_pkg::slot_mask_t free,
    output logic full,
    output logic issue_ready,
    output rs_pkg::rs_packet_t issue_packet,
    output rs_pkg::slot_t issue_slot
);

    import rs_pkg::*;

    // per-entry state
    slot_mask_t busy;
    slot_mask_t issued;
    rs_packet_t entries [bank_depth];

    slot_t free_slot;
    slot_mask_t entry_ready;

    // result-bus hits on the incoming packet
    logic write_src1_hit;
    logic write_src2_hit;

    // lowest non-busy slot; scanning downward leaves the lowest one
    always_comb begin
        free_slot = '0;
        for (int i = bank_depth - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_slot = slot_t'(i);
            end
        end
    end

    assign full = &busy;

    // waiting for issue with both operands available
    always_comb begin
        for (int i = 0; i < bank_depth; i++) begin
            entry_ready[i] = busy[i] && !issued[i]
                             && entries[i].src1.ready && entries[i].src2.ready;
        end
    end

    // highest ready slot is the candidate
    always_comb begin
        issue_slot = '0;
        for (int i = 0; i < bank_depth; i++) begin
            if (entry_ready[i]) begin
                issue_slot = slot_t'(i);
            end
        end
    end

    assign issue_ready = |entry_ready;
    assign issue_packet = entries[issue_slot];

    // a tag broadcast in the allocation cycle counts as ready
    assign write_src1_hit = update && (write_packet.src1.tag == ready_tag);
    assign write_src2_hit = update && (write_packet.src2.tag == ready_tag);

    // busy and issued flags
    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= '0;
            issued <= '1;
        end else begin
            if (issue_grant) begin
                issued[issue_slot] <= 1'b1;
            end

            for (int i = 0; i < bank_depth; i++) begin
                if (free[i]) begin
                    busy[i] <= 1'b0;
                    issued[i] <= 1'b1;
                end
            end

            // the write slot is never busy, so nothing above touches it
            if (write) begin
                busy[free_slot] <= 1'b1;
                issued[free_slot] <= 1'b0;
            end
        end
    end

    // packet storage and operand wakeup
    always_ff @(posedge clock) begin
        if (update) begin
            for (int i = 0; i < bank_depth; i++) begin
                if (entries[i].src1.tag == ready_tag) begin
                    entries[i].src1.ready <= 1'b1;
                end
                if (entries[i].src2.tag == ready_tag) begin
                    entries[i].src2.ready <= 1'b1;
                end
            end
        end

        if (write) begin
            entries[free_slot] <= write_packet;
            entries[free_slot].src1.ready <= write_packet.src1.ready | write_src1_hit;
            entries[free_slot].src2.ready <= write_packet.src2.ready | write_src2_hit;
        end
    end

endmodule

// ==== logic/rs_issue_select.sv ====
module rs_issue_select (
    input  logic clock,
    input  logic reset,
    input  logic issue_enable,
    input  rs_pkg::bank_mask_t issue_ready,
    input  rs_pkg::rs_packet_t bank_packet [rs_pkg::num_fu_types],
    input  rs_pkg::slot_t bank_slot [rs_pkg::num_fu_types],
    output rs_pkg::bank_mask_t issue_grant,
    output rs_pkg::issue_packet_t issued
);

    import rs_pkg::*;

    localparam int bank_idx_width = $clog2(num_fu_types);

    logic [bank_idx_width-1:0] winner;
    logic any_ready;

    assign any_ready = |issue_ready;

    // fixed priority, alu first and branch last
    always_comb begin
        winner = '0;
        for (int i = num_fu_types - 1; i >= 0; i--) begin
            if (issue_ready[i]) begin
                winner = bank_idx_width'(i);
            end
        end
    end

    // at most one grant, and none while issue is held off
    always_comb begin
        issue_grant = '0;
        if (issue_enable && any_ready) begin
            issue_grant[winner] = 1'b1;
        end
    end

    // registered issue output
    always_ff @(posedge clock) begin
        if (reset) begin
            issued <= '0;
        end else if (issue_enable && any_ready) begin
            issued.packet <= bank_packet[winner];
            issued.packet.valid <= 1'b1;
            issued.slot <= bank_slot[winner];
        end else begin
            // nothing ready or issue disabled
            issued.packet.valid <= 1'b0;
        end
    end

endmodule

// ==== logic/rs_pkg.sv ====
package rs_pkg;

    // physical register tags and program counter
    localparam int tag_width = 6;
    localparam int pc_width = 32;

    // bank geometry, identical for every function type
    localparam int bank_depth = 4;
    localparam int slot_width = 2;
    localparam int num_fu_types = 5;

    typedef logic [tag_width-1:0] tag_t;
    typedef logic [slot_width-1:0] slot_t;

    // also the bank index, so the order sets issue priority
    typedef enum logic [2:0] {
        fu_alu = 3'd0,
        fu_mult = 3'd1,
        fu_load = 3'd2,
        fu_store = 3'd3,
        fu_branch = 3'd4
    } fu_type_e;

    typedef struct packed {
        tag_t tag;
        logic ready;
    } src_operand_t;

    typedef struct packed {
        logic valid;
        fu_type_e fu_type;
        logic [pc_width-1:0] pc;
        tag_t dest;
        src_operand_t src1;
        src_operand_t src2;
    } rs_packet_t;

    // slot travels with the packet so the FU can free it later
    typedef struct packed {
        rs_packet_t packet;
        slot_t slot;
    } issue_packet_t;

    // one bit per bank, indexed by fu_type_e
    typedef logic [num_fu_types-1:0] bank_mask_t;
    typedef logic [bank_depth-1:0] slot_mask_t;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# build and run the reservation station testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f tb.f --top-module rs_tb -Mdir obj_dir -o rs_sim

./obj_dir/rs_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// ==== tb.f ====
logic/rs_pkg.sv
logic/rs_alloc_router.sv
logic/rs_bank.sv
logic/rs_issue_select.sv
logic/reservation_station.sv
verif/rs_checker.sv
verif/rs_tb.sv

// ==== verif/rs_checker.sv ====
module rs_checker (
    input  logic clock,
    input  logic reset,
    input  logic done,
    input  rs_pkg::issue_packet_t issued,
    input  rs_pkg::bank_mask_t bank_full,
    input  logic exp_done,
    input  rs_pkg::issue_packet_t exp_issued,
    input  rs_pkg::bank_mask_t exp_full,
    output logic failed
);

    timeunit 1ns;
    timeprecision 1ps;

    import rs_pkg::*;

    // one flag per check, raised by its action block
    bit done_bad;
    bit valid_bad;
    bit packet_bad;
    bit slot_bad;
    bit full_bad;

    assign failed = done_bad | valid_bad | packet_bad | slot_bad | full_bad;

    // done pulse one cycle after an accepted allocation
    done_check: assert property (@(posedge clock) disable iff (reset) done == exp_done)
        else begin
            $display("mismatch done at %0t: dut %h, expected %h", $time, done, exp_done);
            done_bad = 1'b1;
        end

    // an entry issues only when the model has a winner
    valid_check: assert property (@(posedge clock) disable iff (reset)
        issued.packet.valid == exp_issued.packet.valid)
        else begin
            $display("mismatch issued.packet.valid at %0t: dut %h, expected %h",
                     $time, issued.packet.valid, exp_issued.packet.valid);
            valid_bad = 1'b1;
        end

    // stored packet comes back unchanged apart from the ready bits
    packet_check: assert property (@(posedge clock) disable iff (reset)
        !exp_issued.packet.valid || issued.packet == exp_issued.packet)
        else begin
            $display("mismatch issued.packet at %0t: dut %h, expected %h",
                     $time, issued.packet, exp_issued.packet);
            packet_bad = 1'b1;
        end

    // slot index, from lowest-free allocation and highest-ready issue
    slot_check: assert property (@(posedge clock) disable iff (reset)
        !exp_issued.packet.valid || issued.slot == exp_issued.slot)
        else begin
            $display("mismatch issued.slot at %0t: dut %h, expected %h",
                     $time, issued.slot, exp_issued.slot);
            slot_bad = 1'b1;
        end

    full_check: assert property (@(posedge clock) disable iff (reset) bank_full == exp_full)
        else begin
            $display("mismatch bank_full at %0t: dut %h, expected %h",
                     $time, bank_full, exp_full);
            full_bad = 1'b1;
        end

endmodule

// ==== verif/rs_tb.sv ====
module rs_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import rs_pkg::*;

    // cycles in all sequences below including reset
    localparam int sequence_cycles = 71;
    localparam int timeout_limit = 2 * sequence_cycles;

    bit clock;
    logic reset;
    logic allocate;
    rs_packet_t alloc_packet;
    logic update;
    tag_t ready_tag;
    logic issue_enable;
    slot_mask_t free [num_fu_types];
    logic done;
    issue_packet_t issued;
    bank_mask_t bank_full;

    // values for the next driven cycle
    logic req_alloc;
    rs_packet_t req_packet;
    logic req_update;
    tag_t req_tag;
    logic req_enable;
    slot_mask_t req_free [num_fu_types];

    // reference model of every bank
    slot_mask_t model_busy [num_fu_types];
    slot_mask_t model_issued [num_fu_types];
    rs_packet_t model_entry [num_fu_types][bank_depth];
    logic exp_done;
    issue_packet_t exp_issued;
    bank_mask_t exp_full;

    logic check_failed;
    integer seed;
    int cycle_count;
    tag_t wake_a;
    tag_t wake_b;

    always #20 clock = ~clock;

    reservation_station DUT (
        .clock        (clock),
        .reset        (reset),
        .allocate     (allocate),
        .alloc_packet (alloc_packet),
        .update       (update),
        .ready_tag    (ready_tag),
        .issue_enable (issue_enable),
        .free         (free),
        .done         (done),
        .issued       (issued),
        .bank_full    (bank_full)
    );

    rs_checker u_checker (
        .clock      (clock),
        .reset      (reset),
        .done       (done),
        .issued     (issued),
        .bank_full  (bank_full),
        .exp_done   (exp_done),
        .exp_issued (exp_issued),
        .exp_full   (exp_full),
        .failed     (check_failed)
    );

    function automatic int highest_ready(int b);
        int found;
        found = -1;
        for (int s = 0; s < bank_depth; s++) begin
            if (model_busy[b][s] && !model_issued[b][s]
                && model_entry[b][s].src1.ready && model_entry[b][s].src2.ready) begin
                found = s;
            end
        end
        return found;
    endfunction

    function automatic int lowest_free(int b);
        int found;
        found = 0;
        for (int s = bank_depth - 1; s >= 0; s--) begin
            if (!model_busy[b][s]) begin
                found = s;
            end
        end
        return found;
    endfunction

    // predictions settle at the same edge as the DUT registers
    always @(posedge clock) begin : reference_model
        int win;
        int cand;
        int fu;
        int slot;
        logic accept;
        rs_packet_t pkt;
        if (reset) begin
            for (int b = 0; b < num_fu_types; b++) begin
                model_busy[b] = '0;
                model_issued[b] = '1;
            end
            exp_done <= 1'b0;
            exp_issued <= '0;
            exp_full <= '0;
        end else begin
            // alu first and branch last
            win = -1;
            cand = 0;
            for (int b = 0; b < num_fu_types; b++) begin
                if (win < 0 && highest_ready(b) >= 0) begin
                    win = b;
                    cand = highest_ready(b);
                end
            end
            if (issue_enable && win >= 0) begin
                pkt = model_entry[win][cand];
                pkt.valid = 1'b1;
                exp_issued.packet <= pkt;
                exp_issued.slot <= slot_t'(cand);
                model_issued[win][cand] = 1'b1;
            end else begin
                exp_issued.packet.valid <= 1'b0;
            end

            // full and free slot as seen before this edge
            fu = int'(alloc_packet.fu_type);
            accept = 1'b0;
            slot = 0;
            if (allocate && fu < num_fu_types) begin
                accept = !(&model_busy[fu]);
                slot = lowest_free(fu);
            end

            for (int b = 0; b < num_fu_types; b++) begin
                for (int s = 0; s < bank_depth; s++) begin
                    if (free[b][s]) begin
                        model_busy[b][s] = 1'b0;
                        model_issued[b][s] = 1'b1;
                    end
                    if (update && model_entry[b][s].src1.tag == ready_tag) begin
                        model_entry[b][s].src1.ready = 1'b1;
                    end
                    if (update && model_entry[b][s].src2.tag == ready_tag) begin
                        model_entry[b][s].src2.ready = 1'b1;
                    end
                end
            end

            if (accept) begin
                pkt = alloc_packet;
                // broadcast during allocation wakes the new entry too
                if (update && pkt.src1.tag == ready_tag) begin
                    pkt.src1.ready = 1'b1;
                end
                if (update && pkt.src2.tag == ready_tag) begin
                    pkt.src2.ready = 1'b1;
                end
                model_entry[fu][slot] = pkt;
                model_busy[fu][slot] = 1'b1;
                model_issued[fu][slot] = 1'b0;
            end

            exp_done <= accept;
            for (int b = 0; b < num_fu_types; b++) begin
                exp_full[b] <= &model_busy[b];
            end
        end
    end

    function automatic tag_t random_tag();
        return tag_t'($random(seed));
    endfunction

    function automatic rs_packet_t new_packet(fu_type_e fu, tag_t t1, logic r1,
                                              tag_t t2, logic r2);
        rs_packet_t p;
        p.valid = 1'b1;
        p.fu_type = fu;
        p.pc = $random(seed);
        p.dest = random_tag();
        p.src1.tag = t1;
        p.src1.ready = r1;
        p.src2.tag = t2;
        p.src2.ready = r2;
        return p;
    endfunction

    // requests become DUT inputs at the next clock edge
    task automatic drive_cycle();
        @(posedge clock);
        allocate <= req_alloc;
        alloc_packet <= req_packet;
        update <= req_update;
        ready_tag <= req_tag;
        issue_enable <= req_enable;
        for (int b = 0; b < num_fu_types; b++) begin
            free[b] <= req_free[b];
            req_free[b] = '0;
        end
        req_alloc = 1'b0;
        req_update = 1'b0;
    endtask

    task automatic idle(int n);
        repeat (n) drive_cycle();
    endtask

    task automatic alloc_cycle(fu_type_e fu, tag_t t1, logic r1, tag_t t2, logic r2);
        req_alloc = 1'b1;
        req_packet = new_packet(fu, t1, r1, t2, r2);
        drive_cycle();
    endtask

    task automatic free_all();
        for (int b = 0; b < num_fu_types; b++) begin
            req_free[b] = '1;
        end
        drive_cycle();
    endtask

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("timeout: stimulus still running after %0d cycles", timeout_limit);
            $display("TEST RESULT: FAIL");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    always @(posedge check_failed) begin
        $display("TEST RESULT: FAIL");
        $fatal(1, "output check failed");
    end

    initial begin
        seed = 32'h59b4;
        reset = 1'b1;
        allocate = 1'b0;
        alloc_packet = '0;
        update = 1'b0;
        ready_tag = '0;
        issue_enable = 1'b0;
        req_alloc = 1'b0;
        req_packet = '0;
        req_update = 1'b0;
        req_tag = '0;
        req_enable = 1'b0;
        for (int b = 0; b < num_fu_types; b++) begin
            free[b] = '0;
            req_free[b] = '0;
        end
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        idle(2);

        // fill alu and refuse the fifth while other banks still accept
        repeat (5) alloc_cycle(fu_alu, random_tag(), 1'b0, random_tag(), 1'b0);
        alloc_cycle(fu_mult, random_tag(), 1'b0, random_tag(), 1'b0);
        alloc_cycle(fu_type_e'(3'd5), random_tag(), 1'b1, random_tag(), 1'b1);
        alloc_cycle(fu_type_e'(3'd7), random_tag(), 1'b1, random_tag(), 1'b1);
        idle(2);

        // src1 woken in its allocation cycle and src2 later
        wake_a = random_tag();
        wake_b = wake_a + 6'd1;
        req_enable = 1'b1;
        req_update = 1'b1;
        req_tag = wake_a;
        alloc_cycle(fu_load, wake_a, 1'b0, wake_b, 1'b0);
        idle(3);
        req_update = 1'b1;
        req_tag = wake_b;
        drive_cycle();
        idle(3);

        // priority across banks with the highest slot first
        req_enable = 1'b0;
        free_all();
        repeat (2) alloc_cycle(fu_alu, random_tag(), 1'b1, random_tag(), 1'b1);
        repeat (2) alloc_cycle(fu_mult, random_tag(), 1'b1, random_tag(), 1'b1);
        alloc_cycle(fu_load, random_tag(), 1'b1, random_tag(), 1'b1);
        alloc_cycle(fu_store, random_tag(), 1'b1, random_tag(), 1'b1);
        repeat (2) alloc_cycle(fu_branch, random_tag(), 1'b1, random_tag(), 1'b1);
        req_enable = 1'b1;
        idle(10);
        free_all();

        // free slot 2 of a full store bank and reuse it
        req_enable = 1'b0;
        repeat (4) alloc_cycle(fu_store, random_tag(), 1'b1, random_tag(), 1'b1);
        req_free[fu_store] = 4'b0100;
        alloc_cycle(fu_store, random_tag(), 1'b1, random_tag(), 1'b1);
        alloc_cycle(fu_store, random_tag(), 1'b1, random_tag(), 1'b1);
        req_enable = 1'b1;
        idle(6);
        free_all();

        // ready entries held back while issue is off
        req_enable = 1'b0;
        repeat (2) alloc_cycle(fu_alu, random_tag(), 1'b1, random_tag(), 1'b1);
        alloc_cycle(fu_branch, random_tag(), 1'b1, random_tag(), 1'b1);
        idle(4);
        req_enable = 1'b1;
        idle(5);
        free_all();
        idle(2);
        @(negedge clock);

        if (check_failed) begin
            $display("TEST RESULT: FAIL");
            $fatal(1, "output check failed");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule
